// ==== src/secv_pkg.sv ====
// Core-side package with XLEN, tag opcodes, function unit structs and FSM states.

package secv_pkg;

    localparam int XLEN = 32;  // register width.

    // tag opcodes, values 5 to 7 are illegal.
    typedef enum logic [2:0] {
        MTAG_OP_TADR  = 3'd0,  // store tag from src2.
        MTAG_OP_TADRE = 3'd1,  // store tag encoded in src1.
        MTAG_OP_TADRR = 3'd2,  // store random tag and return it.
        MTAG_OP_TLD   = 3'd3,  // load stored tag.
        MTAG_OP_TCHK  = 3'd4   // check encoded tag against stored tag.
    } mtag_op_e;

    // request from the issuing stage.
    typedef struct packed {
        logic            ena;
        mtag_op_e        op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } funit_in_t;

    // response back to the issuing stage.
    typedef struct packed {
        logic            rdy;
        logic            err;
        logic [XLEN-1:0] res;
    } funit_out_t;

    // sequencing of a tag function unit.
    typedef enum logic [1:0] {
        FU_IDLE,  // waiting for ena.
        FU_BUS,   // bus cycle open, waiting for ack.
        FU_DONE   // rdy pulse.
    } fu_state_e;

    function automatic funit_out_t funit_out_default();
        funit_out_t rsp;
        rsp = '0;
        return rsp;
    endfunction

endpackage

// ==== src/tmem_pkg.sv ====
// Tag memory bus package with address and data widths and request and response structs.

package tmem_pkg;

    localparam int TMEM_AW = 16;          // word address width.
    localparam int TMEM_DW = 32;          // data width.
    localparam int TMEM_SW = TMEM_DW / 8; // one select per byte.

    // master to slave.
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [TMEM_SW-1:0] sel;
        logic [TMEM_AW-1:0] adr;
        logic [TMEM_DW-1:0] dat;
    } tmem_req_t;

    // slave to master.
    typedef struct packed {
        logic               ack;
        logic [TMEM_DW-1:0] dat;
    } tmem_rsp_t;

endpackage

// ==== src/tag_rng.sv ====
// Module tag_rng, a free-running 32-bit Galois LFSR.

`timescale 1ns/1ps

module tag_rng (
    input  logic        clk_i,
    input  logic        arst_n_i,
    output logic [31:0] rnd_o
);

    // taps 32,22,2,1 in right-shift Galois form.
    localparam logic [31:0] TAPS = 32'h8020_0003;
    localparam logic [31:0] SEED = 32'hACE1_2468;  // any non-zero value.

    logic [31:0] lfsr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= SEED;
        end else if (lfsr_q[0]) begin
            lfsr_q <= {1'b0, lfsr_q[31:1]} ^ TAPS;
        end else begin
            lfsr_q <= {1'b0, lfsr_q[31:1]};
        end
    end

    // maximal length, so the state never reaches zero.
    assign rnd_o = lfsr_q;

endmodule

// ==== src/mtag.sv ====
// Module mtag, the tag-store function unit with its FSM and bus write request.

`timescale 1ns/1ps

module mtag import secv_pkg::*; import tmem_pkg::*; #(
    parameter int TLEN        = 16,  // tag length in bits.
    parameter int GRANULARITY = 8    // granule size in bytes.
) (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  funit_in_t   fu_i,
    output funit_out_t  fu_o,
    input  logic [31:0] rnd_i,
    output tmem_req_t   tmem_req_o,
    input  tmem_rsp_t   tmem_rsp_i
);

    localparam int TPW  = TMEM_DW / TLEN;  // tags per word.
    localparam int TSEL = TLEN / 8;        // byte selects per tag.
    localparam logic [TMEM_SW-1:0] SEL_BASE = TMEM_SW'((1 << TSEL) - 1);
    localparam logic [XLEN-1:0]    ADR_MASK = {XLEN{1'b1}} >> TLEN;

    fu_state_e       state_q;
    tmem_req_t       req_q;
    logic            err_q;
    logic [XLEN-1:0] res_q;

    logic [XLEN-1:0] gran;
    logic [1:0]      slot;
    logic [TLEN-1:0] rnd_tag;
    logic [TLEN-1:0] wr_tag;
    logic            legal;

    // granule index from the untagged address bits.
    assign gran = (fu_i.src1 & ADR_MASK) / GRANULARITY;
    assign slot = 2'(gran % TPW);

    // zero is reserved, so a zero draw maps to 1.
    assign rnd_tag = (TLEN'(rnd_i) != '0) ? TLEN'(rnd_i) : TLEN'(1);

    always_comb begin
        legal  = 1'b1;
        wr_tag = '0;
        case (fu_i.op)
            MTAG_OP_TADR:  wr_tag = TLEN'(fu_i.src2);
            MTAG_OP_TADRE: wr_tag = fu_i.src1[XLEN-1 -: TLEN];
            MTAG_OP_TADRR: wr_tag = rnd_tag;
            default:       legal  = 1'b0;  // loads and checks belong to mtag_chk.
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FU_IDLE;
            req_q   <= '0;
            err_q   <= 1'b0;
            res_q   <= '0;
        end else begin
            case (state_q)
                FU_IDLE: if (fu_i.ena) begin
                    err_q <= ~legal;
                    res_q <= (fu_i.op == MTAG_OP_TADRR) ? XLEN'(rnd_tag) : '0;
                    if (legal) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= 1'b1;
                        req_q.sel <= SEL_BASE << (slot * TSEL);
                        req_q.adr <= TMEM_AW'(gran / TPW);
                        req_q.dat <= TMEM_DW'(wr_tag) << (slot * TLEN);
                        state_q   <= FU_BUS;
                    end else begin
                        state_q <= FU_DONE;  // no bus access.
                    end
                end
                FU_BUS: if (tmem_rsp_i.ack) begin
                    req_q.cyc <= 1'b0;
                    req_q.stb <= 1'b0;
                    req_q.we  <= 1'b0;
                    state_q   <= FU_DONE;
                end
                default: state_q <= FU_IDLE;
            endcase
        end
    end

    assign tmem_req_o = req_q;

    always_comb begin
        fu_o     = funit_out_default();
        fu_o.rdy = (state_q == FU_DONE);
        fu_o.err = err_q;
        fu_o.res = res_q;
    end

endmodule

// ==== src/mtag_chk.sv ====
// Module mtag_chk, the tag-load and tag-check function unit with its FSM and compare.

`timescale 1ns/1ps

module mtag_chk import secv_pkg::*; import tmem_pkg::*; #(
    parameter int TLEN        = 16,  // tag length in bits.
    parameter int GRANULARITY = 8    // granule size in bytes.
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  funit_in_t  fu_i,
    output funit_out_t fu_o,
    output tmem_req_t  tmem_req_o,
    input  tmem_rsp_t  tmem_rsp_i
);

    localparam int TPW  = TMEM_DW / TLEN;
    localparam int TSEL = TLEN / 8;
    localparam logic [TMEM_SW-1:0] SEL_BASE = TMEM_SW'((1 << TSEL) - 1);
    localparam logic [XLEN-1:0]    ADR_MASK = {XLEN{1'b1}} >> TLEN;

    fu_state_e       state_q;
    tmem_req_t       req_q;
    logic            err_q;
    logic [XLEN-1:0] res_q;
    logic [1:0]      slot_q;   // tag slot of the pending read.
    logic            chk_q;    // pending op is TCHK.
    logic [TLEN-1:0] enc_q;    // encoded tag of the pending TCHK.

    logic [XLEN-1:0] gran;
    logic [1:0]      slot;
    logic [TLEN-1:0] rd_tag;
    logic            legal;

    assign gran  = (fu_i.src1 & ADR_MASK) / GRANULARITY;
    assign slot  = 2'(gran % TPW);
    assign legal = (fu_i.op == MTAG_OP_TLD) || (fu_i.op == MTAG_OP_TCHK);

    // pick this granule's tag out of the returned word.
    assign rd_tag = TLEN'(tmem_rsp_i.dat >> (slot_q * TLEN));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FU_IDLE;
            req_q   <= '0;
            err_q   <= 1'b0;
            res_q   <= '0;
            slot_q  <= '0;
            chk_q   <= 1'b0;
            enc_q   <= '0;
        end else begin
            case (state_q)
                FU_IDLE: if (fu_i.ena) begin
                    err_q <= ~legal;  // stores and unused codes fail at once.
                    res_q <= '0;
                    if (legal) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        req_q.we  <= 1'b0;
                        req_q.sel <= SEL_BASE << (slot * TSEL);
                        req_q.adr <= TMEM_AW'(gran / TPW);
                        req_q.dat <= '0;
                        slot_q    <= slot;
                        chk_q     <= (fu_i.op == MTAG_OP_TCHK);
                        enc_q     <= fu_i.src1[XLEN-1 -: TLEN];
                        state_q   <= FU_BUS;
                    end else begin
                        state_q <= FU_DONE;
                    end
                end
                FU_BUS: if (tmem_rsp_i.ack) begin
                    req_q.cyc <= 1'b0;
                    req_q.stb <= 1'b0;
                    res_q     <= chk_q ? '0 : XLEN'(rd_tag);
                    err_q     <= chk_q && (rd_tag != enc_q);  // tag mismatch.
                    state_q   <= FU_DONE;
                end
                default: state_q <= FU_IDLE;
            endcase
        end
    end

    assign tmem_req_o = req_q;

    always_comb begin
        fu_o     = funit_out_default();
        fu_o.rdy = (state_q == FU_DONE);
        fu_o.err = err_q;
        fu_o.res = res_q;
    end

endmodule

// ==== src/tmem_arbiter.sv ====
// Module tmem_arbiter, a two-master round-robin arbiter with bus locking.

`timescale 1ns/1ps

module tmem_arbiter import tmem_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  tmem_req_t m0_req_i,
    input  tmem_req_t m1_req_i,
    output tmem_rsp_t m0_rsp_o,
    output tmem_rsp_t m1_rsp_o,
    output tmem_req_t s_req_o,
    input  tmem_rsp_t s_rsp_i
);

    logic locked_q;  // owner held cyc in the last cycle.
    logic owner_q;   // master that owns the bus while locked.
    logic last_q;    // winner of the latest fresh arbitration.
    logic gnt;
    logic gnt_vld;
    logic hold;

    assign hold    = locked_q && (owner_q ? m1_req_i.cyc : m0_req_i.cyc);
    assign gnt_vld = m0_req_i.cyc | m1_req_i.cyc;

    always_comb begin
        if (hold) begin
            gnt = owner_q;  // bus stays locked for the whole cycle.
        end else if (m0_req_i.cyc && m1_req_i.cyc) begin
            gnt = ~last_q;  // both want it, the other one's turn.
        end else begin
            gnt = m1_req_i.cyc;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            locked_q <= 1'b0;
            owner_q  <= 1'b0;
            last_q   <= 1'b1;  // m0 wins the first tie.
        end else begin
            locked_q <= gnt_vld;
            owner_q  <= gnt;
            if (gnt_vld && !hold) last_q <= gnt;
        end
    end

    always_comb begin
        s_req_o  = '0;
        m0_rsp_o = '0;
        m1_rsp_o = '0;
        if (gnt_vld) begin
            s_req_o = gnt ? m1_req_i : m0_req_i;
            if (gnt) m1_rsp_o = s_rsp_i;
            else     m0_rsp_o = s_rsp_i;
        end
    end

endmodule

// ==== src/tag_mem.sv ====
// Module tag_mem, the byte-writable tag word array acting as a bus slave.

`timescale 1ns/1ps

module tag_mem import tmem_pkg::*; #(
    parameter int DEPTH = 256  // number of tag words.
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  tmem_req_t req_i,
    output tmem_rsp_t rsp_o
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [TMEM_DW-1:0] mem_q [DEPTH];
    logic [TMEM_DW-1:0] dat_q;
    logic               ack_q;
    logic [IW-1:0]      idx;
    logic               take;

    assign idx  = IW'(req_i.adr);
    // no new sample during the ack cycle, the master still holds the request.
    assign take = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) mem_q[i] <= '0;  // fresh granules carry tag 0.
            dat_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
            if (take) begin
                dat_q <= mem_q[idx];
                if (req_i.we) begin
                    for (int b = 0; b < TMEM_SW; b++) begin
                        if (req_i.sel[b]) mem_q[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

// ==== src/mtag_top.sv ====
// Module mtag_top, the memory-tagging block with both units, LFSR, arbiter and tag memory.

`timescale 1ns/1ps

module mtag_top import secv_pkg::*; import tmem_pkg::*; #(
    parameter int TLEN        = 16,   // multiple of 8, at most 32.
    parameter int GRANULARITY = 8,    // power of two.
    parameter int DEPTH       = 256
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  funit_in_t  mtag_fu_i,
    output funit_out_t mtag_fu_o,
    input  funit_in_t  chk_fu_i,
    output funit_out_t chk_fu_o
);

    logic [31:0] rnd;
    tmem_req_t   mtag_req;
    tmem_rsp_t   mtag_rsp;
    tmem_req_t   chk_req;
    tmem_rsp_t   chk_rsp;
    tmem_req_t   mem_req;
    tmem_rsp_t   mem_rsp;

    tag_rng i_rng (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rnd_o    (rnd)
    );

    // store unit, master 0.
    mtag #(
        .TLEN        (TLEN),
        .GRANULARITY (GRANULARITY)
    ) i_mtag (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .fu_i       (mtag_fu_i),
        .fu_o       (mtag_fu_o),
        .rnd_i      (rnd),
        .tmem_req_o (mtag_req),
        .tmem_rsp_i (mtag_rsp)
    );

    // load and check unit, master 1.
    mtag_chk #(
        .TLEN        (TLEN),
        .GRANULARITY (GRANULARITY)
    ) i_mtag_chk (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .fu_i       (chk_fu_i),
        .fu_o       (chk_fu_o),
        .tmem_req_o (chk_req),
        .tmem_rsp_i (chk_rsp)
    );

    tmem_arbiter i_arb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .m0_req_i (mtag_req),
        .m1_req_i (chk_req),
        .m0_rsp_o (mtag_rsp),
        .m1_rsp_o (chk_rsp),
        .s_req_o  (mem_req),
        .s_rsp_i  (mem_rsp)
    );

    tag_mem #(
        .DEPTH (DEPTH)
    ) i_tag_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp)
    );

endmodule

// ==== tb/tb_mtag_top.sv ====
// Testbench tb_mtag_top with tag reference model, request and compare tasks, and watchdog.

`timescale 1ns/1ps

module tb_mtag_top import secv_pkg::*; ();

    localparam int TLEN        = 16;
    localparam int GRANULARITY = 8;
    localparam int DEPTH       = 256;
    localparam int NGRAN       = DEPTH * (32 / TLEN);  // granules covered by the memory.
    localparam int N1 = 16;
    localparam int N2 = 8;
    localparam int N3 = 8;
    localparam int N4 = 4;
    localparam int N5 = 16;
    localparam int N_REQ = 4 * N1 + 5 * N2 + 2 * N3 + 13 * N4 + 3 * N5;
    localparam int RDY_LIMIT = 20;
    localparam int WD_NS = (N_REQ * 20 + 10) * 40;

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    funit_in_t  mtag_fu_i;
    funit_out_t mtag_fu_o;
    funit_in_t  chk_fu_i;
    funit_out_t chk_fu_o;

    logic [TLEN-1:0] tag_model [NGRAN];  // expected tag per granule.
    int err_cnt = 0;
    int n_checks = 0;
    int req_cnt [2] = '{0, 0};
    int rdy_cnt [2] = '{0, 0};

    // responses waiting for the compare process.
    string           name_q[$];
    logic [XLEN-1:0] exp_res_q[$];
    logic            exp_err_q[$];
    bit              nz_q[$];
    funit_out_t      got_q[$];

    mtag_top UUT (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .mtag_fu_i (mtag_fu_i),
        .mtag_fu_o (mtag_fu_o),
        .chk_fu_i  (chk_fu_i),
        .chk_fu_o  (chk_fu_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic int granule_of(input logic [XLEN-1:0] ptr);
        return (int'(ptr[XLEN-TLEN-1:0]) / GRANULARITY) % NGRAN;
    endfunction

    // expected stored tag for the granule a pointer falls in.
    function automatic logic [TLEN-1:0] ref_tag(input logic [XLEN-1:0] ptr);
        return tag_model[granule_of(ptr)];
    endfunction

    // pointer to a random byte of a granule with the tag in the top bits.
    function automatic logic [XLEN-1:0] make_ptr(input logic [TLEN-1:0] tag, input int gran);
        logic [XLEN-1:0] adr;
        adr = XLEN'(gran * GRANULARITY + $urandom_range(0, GRANULARITY - 1));
        return adr | (XLEN'(tag) << (XLEN - TLEN));
    endfunction

    task automatic check_res(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED %s: expected res %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED %s: expected err %b, actual %b", name, exp, act);
        end
    endtask

    // holds ena until rdy, then queues the response for comparison.
    task automatic issue_request(input bit unit, input mtag_op_e op, input logic [XLEN-1:0] s1,
                                 input logic [XLEN-1:0] s2, input string name,
                                 input logic [XLEN-1:0] exp_res, input logic exp_err,
                                 input bit nz, input int exp_lat, output funit_out_t rsp);
        funit_in_t  req;
        funit_out_t got;
        int         lat;
        req.ena  = 1'b1;
        req.op   = op;
        req.src1 = s1;
        req.src2 = s2;
        if (unit) chk_fu_i = req;
        else      mtag_fu_i = req;
        lat = 0;
        got = '0;
        while (!got.rdy && lat < RDY_LIMIT) begin
            @(negedge clk_i);
            lat++;
            got = unit ? chk_fu_o : mtag_fu_o;
        end
        if (unit) chk_fu_i = '0;
        else      mtag_fu_i = '0;
        if (!got.rdy) begin
            err_cnt++;
            $display("%s: no rdy within %0d cycles", name, RDY_LIMIT);
        end else begin
            name_q.push_back(name);
            exp_res_q.push_back(exp_res);
            exp_err_q.push_back(exp_err);
            nz_q.push_back(nz);
            got_q.push_back(got);
            if (exp_lat != 0 && lat != exp_lat) begin
                err_cnt++;
                $display("FAILED %s: expected latency %0d, actual %0d", name, exp_lat, lat);
            end
        end
        @(negedge clk_i);
        if (unit ? chk_fu_o.rdy : mtag_fu_o.rdy) begin
            err_cnt++;
            $display("%s: rdy stayed high for more than one cycle", name);
        end
        req_cnt[unit]++;
        rsp = got;
    endtask

    always @(negedge clk_i) begin : compare
        funit_out_t      got;
        string           name;
        logic [XLEN-1:0] exp;
        bit              nz;
        if (mtag_fu_o.rdy) rdy_cnt[0]++;
        if (chk_fu_o.rdy)  rdy_cnt[1]++;
        while (got_q.size() > 0) begin
            got  = got_q.pop_front();
            name = name_q.pop_front();
            exp  = exp_res_q.pop_front();
            nz   = nz_q.pop_front();
            check_err(name, exp_err_q.pop_front(), got.err);
            if (nz) begin
                n_checks++;
                if (got.res == '0 || (got.res >> TLEN) != '0) begin
                    err_cnt++;
                    $display("%s: random tag %h is zero or wider than a tag", name,
                             got.res);
                end
            end else begin
                check_res(name, exp, got.res);
            end
        end
    end

    initial begin
        #(WD_NS);
        $display("watchdog expired, the requests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        funit_out_t      rsp;
        funit_out_t      rsp_b;
        logic [XLEN-1:0] p;
        logic [XLEN-1:0] s2;
        logic [TLEN-1:0] tag;
        int              g;
        int              gb;
        void'($urandom(2374));
        for (int i = 0; i < NGRAN; i++) tag_model[i] = '0;  // memory resets to tag 0.
        arst_n_i  = 1'b0;
        mtag_fu_i = '0;
        chk_fu_i  = '0;
        repeat (3) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        // tag from register, load and check.
        for (int i = 0; i < N1; i++) begin
            g   = $urandom_range(0, NGRAN - 1);
            s2  = $urandom;
            tag = TLEN'(s2);
            p   = make_ptr(TLEN'($urandom), g);
            issue_request(0, MTAG_OP_TADR, p, s2, "tadr", '0, 1'b0, 0, 3, rsp);
            tag_model[g] = tag;
            issue_request(1, MTAG_OP_TLD, p, '0, "tld after tadr", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
            issue_request(1, MTAG_OP_TCHK, make_ptr(ref_tag(p), g), '0, "tchk match", '0,
                          1'b0, 0, 3, rsp);
            issue_request(1, MTAG_OP_TCHK, make_ptr(ref_tag(p) + TLEN'($urandom_range(1, 100)),
                          g), '0, "tchk mismatch", '0, 1'b1, 0, 3, rsp);
        end

        // known neighbor tag first, then a tag encoded in the pointer.
        for (int i = 0; i < N2; i++) begin
            g   = $urandom_range(0, NGRAN - 1);
            s2  = $urandom | 32'h1;  // odd values keep the neighbor tag non-zero.
            issue_request(0, MTAG_OP_TADR, make_ptr(TLEN'($urandom), g ^ 1), s2,
                          "tadr neighbor", '0, 1'b0, 0, 3, rsp);
            tag_model[g ^ 1] = TLEN'(s2);
            tag = TLEN'($urandom);
            p   = make_ptr(tag, g);
            issue_request(0, MTAG_OP_TADRE, p, $urandom, "tadre", '0, 1'b0, 0, 3, rsp);
            tag_model[g] = tag;
            issue_request(1, MTAG_OP_TLD, p, '0, "tld after tadre", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
            p = make_ptr(TLEN'($urandom), g);
            issue_request(1, MTAG_OP_TLD, p, '0, "tld same granule", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
            p = make_ptr(TLEN'($urandom), g ^ 1);
            issue_request(1, MTAG_OP_TLD, p, '0, "tld neighbor", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
        end

        for (int i = 0; i < N3; i++) begin
            g = $urandom_range(0, NGRAN - 1);
            p = make_ptr(TLEN'($urandom), g);
            issue_request(0, MTAG_OP_TADRR, p, '0, "tadrr", '0, 1'b0, 1, 3, rsp);
            tag_model[g] = TLEN'(rsp.res);  // random tag is known only from res.
            issue_request(1, MTAG_OP_TLD, p, '0, "tld after tadrr", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
        end

        // illegal and cross-unit opcodes touch no granule.
        for (int i = 0; i < N4; i++) begin
            g = $urandom_range(0, NGRAN - 1);
            p = make_ptr(TLEN'($urandom), g);
            s2 = $urandom;
            issue_request(0, MTAG_OP_TADR, p, s2, "tadr before illegal", '0, 1'b0, 0, 3, rsp);
            tag_model[g] = TLEN'(s2);
            for (int k = 0; k < 8; k++) begin
                p = make_ptr(TLEN'($urandom), g);
                if (k >= 3) begin
                    issue_request(0, mtag_op_e'(3'(k)), p, $urandom, "mtag illegal op", '0,
                                  1'b1, 0, 1, rsp);
                end
                if (k < 3 || k >= 5) begin
                    issue_request(1, mtag_op_e'(3'(k)), p, $urandom, "chk illegal op", '0,
                                  1'b1, 0, 1, rsp);
                end
            end
            issue_request(1, MTAG_OP_TLD, p, '0, "tld after illegal", XLEN'(ref_tag(p)), 1'b0,
                          0, 3, rsp);
        end

        // both units in the same cycle, different granules.
        for (int i = 0; i < N5; i++) begin
            g  = $urandom_range(0, NGRAN - 1);
            gb = (g + 1 + $urandom_range(0, NGRAN - 2)) % NGRAN;
            s2 = $urandom;
            p  = make_ptr(TLEN'($urandom), g);
            fork
                issue_request(0, MTAG_OP_TADR, p, s2, "tadr concurrent", '0, 1'b0, 0, 0, rsp);
                if (i % 2) begin
                    issue_request(1, MTAG_OP_TCHK, make_ptr(tag_model[gb], gb), '0,
                                  "tchk concurrent", '0, 1'b0, 0, 0, rsp_b);
                end else begin
                    issue_request(1, MTAG_OP_TLD, make_ptr(TLEN'($urandom), gb), '0,
                                  "tld concurrent", XLEN'(tag_model[gb]), 1'b0, 0, 0, rsp_b);
                end
            join
            tag_model[g] = TLEN'(s2);
            issue_request(1, MTAG_OP_TLD, p, '0, "tld after concurrent", XLEN'(ref_tag(p)),
                          1'b0, 0, 3, rsp);
        end

        repeat (2) @(negedge clk_i);
        for (int u = 0; u < 2; u++) begin
            if (rdy_cnt[u] != req_cnt[u]) begin
                err_cnt++;
                $display("FAILED rdy pulses of unit %0d: expected %0d, actual %0d", u,
                         req_cnt[u], rdy_cnt[u]);
            end
        end
        $display("%0d requests, %0d checks, %0d errors", req_cnt[0] + req_cnt[1], n_checks,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/secv_pkg.sv
src/tmem_pkg.sv
src/tag_rng.sv
src/mtag.sv
src/mtag_chk.sv
src/tmem_arbiter.sv
src/tag_mem.sv
src/mtag_top.sv
tb/tb_mtag_top.sv

// ==== Bender.yml ====
package:
  name: mtag

dependencies: {}

sources:
  # packages first, then the design bottom up
  - src/secv_pkg.sv
  - src/tmem_pkg.sv
  - src/tag_rng.sv
  - src/mtag.sv
  - src/mtag_chk.sv
  - src/tmem_arbiter.sv
  - src/tag_mem.sv
  - src/mtag_top.sv

  - target: test
    files:
      - tb/tb_mtag_top.sv
